//--- design/watch_pkg.sv
package watch_pkg;

    //----------------------------------------------------------------------
    // Modes, one-hot so the value can drive the mode LEDs directly
    //----------------------------------------------------------------------
    typedef enum logic [2:0] {
        WATCH      = 3'b001,
        COOK_TIMER = 3'b010,
        STOPWATCH  = 3'b100
    } mode_t;

    localparam int FIELD_W = 7;            // Holds 0 to 99

    typedef logic [FIELD_W-1:0] field_t;

    localparam field_t SEC_MAX  = 7'd59;
    localparam field_t MIN_MAX  = 7'd59;
    localparam field_t CSEC_MAX = 7'd99;

    // Routed button pulses, start sits on bit 0 like button 0
    typedef struct packed {
        logic inc_high;
        logic inc_low;
        logic start;
    } func_btn_t;

    typedef struct packed {
        field_t high;                      // Left two digits
        field_t low;                       // Right two digits
    } disp_fields_t;

    typedef struct packed {
        logic sec;
        logic csec;
    } tick_t;

    // Count up by one, back to zero past the limit
    function automatic field_t wrap_inc(input field_t value, input field_t max_value);
        if (value >= max_value) begin
            return '0;
        end
        return value + 1'b1;
    endfunction

endpackage

//--- design/button_cntr.sv
`timescale 1ns/1ps

module button_cntr #(
    parameter int DEBOUNCE_CLKS = 100_000
) (
    input  logic clk,
    input  logic reset_p,
    input  logic btn,
    output logic pedge
);

    localparam int CNT_W = $clog2(DEBOUNCE_CLKS + 1);

    logic [CNT_W-1:0] div_cnt;
    logic             btn_sync;            // Raw input, one flop
    logic             last_sample;
    logic             sample_en;

    assign sample_en = (div_cnt == CNT_W'(DEBOUNCE_CLKS - 1));

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            div_cnt     <= '0;
            btn_sync    <= 1'b0;
            last_sample <= 1'b0;
            pedge       <= 1'b0;
        end else begin
            btn_sync <= btn;
            // Low sample followed by a high one
            pedge    <= sample_en && !last_sample && btn_sync;
            if (sample_en) begin
                div_cnt     <= '0;
                last_sample <= btn_sync;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    a_pedge_single: assert property (@(posedge clk) disable iff (reset_p)
        pedge |=> !pedge);

endmodule

//--- design/time_base.sv
`timescale 1ns/1ps

module time_base import watch_pkg::*; #(
    parameter int CLKS_PER_CSEC = 1_000_000
) (
    input  logic  clk,
    input  logic  reset_p,
    output tick_t tick
);

    localparam int DIV_W = $clog2(CLKS_PER_CSEC + 1);

    logic [DIV_W-1:0] div_cnt;
    field_t           csec_cnt;            // 0 to 99

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            div_cnt  <= '0;
            csec_cnt <= '0;
            tick     <= '0;
        end else begin
            tick <= '0;
            if (div_cnt == DIV_W'(CLKS_PER_CSEC - 1)) begin
                div_cnt   <= '0;
                tick.csec <= 1'b1;
                if (csec_cnt == CSEC_MAX) begin
                    csec_cnt <= '0;
                    tick.sec <= 1'b1;      // Rides on the hundredth csec
                end else begin
                    csec_cnt <= csec_cnt + 1'b1;
                end
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

endmodule

//--- design/clock_watch.sv
`timescale 1ns/1ps

module clock_watch import watch_pkg::*; (
    input  logic         clk,
    input  logic         reset_p,
    input  tick_t        tick,
    input  func_btn_t    btn,
    output disp_fields_t fields
);

    logic   set_mode;
    field_t sec;
    field_t min;

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            set_mode <= 1'b0;
            sec      <= '0;
            min      <= '0;
        end else begin
            if (btn.start) begin
                set_mode <= !set_mode;
            end

            if (set_mode) begin
                // Time held, buttons adjust each field
                if (btn.inc_low) begin
                    sec <= wrap_inc(sec, SEC_MAX);
                end
                if (btn.inc_high) begin
                    min <= wrap_inc(min, MIN_MAX);
                end
            end else if (tick.sec) begin
                sec <= wrap_inc(sec, SEC_MAX);
                if (sec == SEC_MAX) begin
                    min <= wrap_inc(min, MIN_MAX);   // Carry
                end
            end
        end
    end

    assign fields.high = min;
    assign fields.low  = sec;

endmodule

//--- design/cook_timer.sv
`timescale 1ns/1ps

module cook_timer import watch_pkg::*; (
    input  logic         clk,
    input  logic         reset_p,
    input  tick_t        tick,
    input  func_btn_t    btn,
    input  logic         alarm_off,
    output disp_fields_t fields,
    output logic         alarm
);

    typedef enum logic [1:0] {
        IDLE,
        COUNT,
        ALARM
    } state_t;

    state_t state;
    field_t sec;
    field_t min;
    logic   time_zero;

    assign time_zero = (min == '0) && (sec == '0);

    //----------------------------------------------------------------------
    // Entry, countdown and alarm
    //----------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            state <= IDLE;
            sec   <= '0;
            min   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (btn.inc_low) begin
                        sec <= wrap_inc(sec, SEC_MAX);
                    end
                    if (btn.inc_high) begin
                        min <= wrap_inc(min, MIN_MAX);
                    end
                    if (btn.start && !time_zero) begin
                        state <= COUNT;
                    end
                end
                COUNT: begin
                    if (btn.start) begin
                        state <= IDLE;             // Pause, time kept
                    end else if (tick.sec) begin
                        if (sec == '0) begin
                            sec <= SEC_MAX;        // Borrow from minutes
                            min <= min - 1'b1;
                        end else begin
                            sec <= sec - 1'b1;
                        end
                        if (min == '0 && sec == 7'd1) begin
                            state <= ALARM;
                        end
                    end
                end
                ALARM: begin
                    if (alarm_off) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign alarm       = (state == ALARM);
    assign fields.high = min;
    assign fields.low  = sec;

    a_alarm_at_zero: assert property (@(posedge clk) disable iff (reset_p)
        alarm |-> time_zero);

endmodule

//--- design/stop_watch.sv
`timescale 1ns/1ps

module stop_watch import watch_pkg::*; (
    input  logic         clk,
    input  logic         reset_p,
    input  tick_t        tick,
    input  func_btn_t    btn,
    output disp_fields_t fields,
    output logic         running,
    output logic         lap
);

    field_t sec;
    field_t csec;
    field_t lap_sec;                       // Frozen copy for the lap view
    field_t lap_csec;

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            running <= 1'b0;
            lap     <= 1'b0;
            sec     <= '0;
            csec    <= '0;
        end else begin
            if (btn.start) begin
                running <= !running;
            end
            if (running && tick.csec) begin
                csec <= wrap_inc(csec, CSEC_MAX);
                if (csec == CSEC_MAX) begin
                    sec <= wrap_inc(sec, SEC_MAX);
                end
            end
            if (btn.inc_low) begin
                lap <= !lap;
            end
            // Clear only while stopped, overrides the lap toggle
            if (btn.inc_high && !running) begin
                sec  <= '0;
                csec <= '0;
                lap  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (btn.inc_low && !lap) begin
            lap_sec  <= sec;
            lap_csec <= csec;
        end
    end

    assign fields.high = lap ? lap_sec : sec;
    assign fields.low  = lap ? lap_csec : csec;

endmodule

//--- design/mode_select.sv
`timescale 1ns/1ps

module mode_select import watch_pkg::*; (
    input  logic         clk,
    input  logic         reset_p,
    input  logic         mode_pedge,
    input  func_btn_t    func_btn,
    input  disp_fields_t watch_fields,
    input  disp_fields_t cook_fields,
    input  disp_fields_t stop_fields,
    output mode_t        mode,
    output func_btn_t    watch_btn,
    output func_btn_t    cook_btn,
    output func_btn_t    stop_btn,
    output disp_fields_t disp
);

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            mode <= WATCH;
        end else if (mode_pedge) begin
            case (mode)
                WATCH:      mode <= COOK_TIMER;
                COOK_TIMER: mode <= STOPWATCH;
                default:    mode <= WATCH;
            endcase
        end
    end

    // Buttons and display follow the active function only
    always_comb begin
        watch_btn = '0;
        cook_btn  = '0;
        stop_btn  = '0;
        disp      = watch_fields;
        case (mode)
            COOK_TIMER: begin
                cook_btn = func_btn;
                disp     = cook_fields;
            end
            STOPWATCH: begin
                stop_btn = func_btn;
                disp     = stop_fields;
            end
            default: watch_btn = func_btn;
        endcase
    end

    a_mode_onehot: assert property (@(posedge clk) disable iff (reset_p) $onehot(mode));

endmodule

//--- design/fnd_cntr.sv
`timescale 1ns/1ps

module fnd_cntr import watch_pkg::*; #(
    parameter int SCAN_CLKS = 100_000
) (
    input  logic         clk,
    input  logic         reset_p,
    input  disp_fields_t disp,
    output logic [7:0]   seg,
    output logic [3:0]   com
);

    localparam int SCAN_W = $clog2(SCAN_CLKS + 1);

    logic [SCAN_W-1:0] scan_cnt;
    logic [1:0]        digit_sel;          // 0 is the rightmost digit
    logic [3:0]        bcd_digit;
    logic [6:0]        seg_a_to_g;         // Bit 0 is segment a

    //----------------------------------------------------------------------
    // Digit scan
    //----------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            scan_cnt  <= '0;
            digit_sel <= 2'd0;
        end else if (scan_cnt == SCAN_W'(SCAN_CLKS - 1)) begin
            scan_cnt  <= '0;
            digit_sel <= digit_sel + 1'b1;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    assign com = ~(4'b0001 << digit_sel);  // Active low

    // Binary field to BCD, only the selected digit
    always_comb begin
        case (digit_sel)
            2'd0:    bcd_digit = 4'(disp.low % 7'd10);
            2'd1:    bcd_digit = 4'(disp.low / 7'd10);
            2'd2:    bcd_digit = 4'(disp.high % 7'd10);
            default: bcd_digit = 4'(disp.high / 7'd10);
        endcase
    end

    //----------------------------------------------------------------------
    // Seven-segment patterns, active low
    //----------------------------------------------------------------------
    always_comb begin
        case (bcd_digit)
            4'd0:    seg_a_to_g = 7'b100_0000;
            4'd1:    seg_a_to_g = 7'b111_1001;
            4'd2:    seg_a_to_g = 7'b010_0100;
            4'd3:    seg_a_to_g = 7'b011_0000;
            4'd4:    seg_a_to_g = 7'b001_1001;
            4'd5:    seg_a_to_g = 7'b001_0010;
            4'd6:    seg_a_to_g = 7'b000_0010;
            4'd7:    seg_a_to_g = 7'b111_1000;
            4'd8:    seg_a_to_g = 7'b000_0000;
            4'd9:    seg_a_to_g = 7'b001_0000;
            default: seg_a_to_g = 7'b111_1111;  // Blank
        endcase
    end

    assign seg = {1'b1, seg_a_to_g};       // Decimal point off

endmodule

//--- design/multifunction_watch_top.sv
`timescale 1ns/1ps

module multifunction_watch_top import watch_pkg::*; #(
    parameter int DEBOUNCE_CLKS = 100_000,
    parameter int CLKS_PER_CSEC = 1_000_000,
    parameter int SCAN_CLKS     = 100_000
) (
    input  logic        clk,
    input  logic        reset_p,
    input  logic [3:0]  button,
    input  logic [15:0] slide,
    output logic [7:0]  seg,
    output logic [3:0]  com,
    output logic [15:0] led,
    output logic        buz
);

    logic [3:0]   btn_pedge;
    func_btn_t    func_btn, watch_btn, cook_btn, stop_btn;
    tick_t        tick;
    mode_t        mode;
    disp_fields_t watch_fields, cook_fields, stop_fields, disp;
    logic         alarm, running, lap;

    for (genvar i = 0; i < 4; i++) begin : g_btn
        button_cntr #(.DEBOUNCE_CLKS(DEBOUNCE_CLKS)) u_btn (
            .clk(clk), .reset_p(reset_p), .btn(button[i]), .pedge(btn_pedge[i]));
    end

    assign func_btn = func_btn_t'(btn_pedge[2:0]);

    time_base #(.CLKS_PER_CSEC(CLKS_PER_CSEC)) u_time_base (
        .clk(clk), .reset_p(reset_p), .tick(tick));

    clock_watch u_watch (.clk(clk), .reset_p(reset_p), .tick(tick), .btn(watch_btn),
                         .fields(watch_fields));

    cook_timer u_cook (.clk(clk), .reset_p(reset_p), .tick(tick), .btn(cook_btn),
                       .alarm_off(slide[0]), .fields(cook_fields), .alarm(alarm));

    stop_watch u_stop (.clk(clk), .reset_p(reset_p), .tick(tick), .btn(stop_btn),
                       .fields(stop_fields), .running(running), .lap(lap));

    mode_select u_mode (.clk(clk), .reset_p(reset_p), .mode_pedge(btn_pedge[3]),
                        .func_btn(func_btn), .watch_fields(watch_fields),
                        .cook_fields(cook_fields), .stop_fields(stop_fields), .mode(mode),
                        .watch_btn(watch_btn), .cook_btn(cook_btn), .stop_btn(stop_btn),
                        .disp(disp));

    fnd_cntr #(.SCAN_CLKS(SCAN_CLKS)) u_fnd (
        .clk(clk), .reset_p(reset_p), .disp(disp), .seg(seg), .com(com));

    // Alarm on 15, mode on 7:5, lap and run state on 1:0
    assign led = {alarm, 7'b0, mode, 3'b0, lap, running};
    assign buz = alarm;

endmodule

//--- testbench/tb_multifunction_watch.sv
`timescale 1ns/1ps

module tb_multifunction_watch import watch_pkg::*; ();

    localparam int DEBOUNCE_CLKS  = 4;
    localparam int CLKS_PER_CSEC  = 5;
    localparam int SCAN_CLKS      = 2;
    localparam int SEC_CLKS       = 100 * CLKS_PER_CSEC;
    localparam int PRESS_COUNT    = 30;
    localparam int RUN_WAITS      = 6000;   // Free-running waits and display reads
    localparam int TIMEOUT_CYCLES = (3000 * PRESS_COUNT + RUN_WAITS) * 2;

    logic        clk;
    logic        reset_p;
    logic [3:0]  button;
    logic [15:0] slide;
    logic [7:0]  seg;
    logic [3:0]  com;
    logic [15:0] led;
    logic        buz;

    int           errors;
    int           scan_errors;              // From the display monitor
    int           checks;
    int           cycle_count;
    int           alarm_rises;
    logic         last_alarm;
    logic [2:0]   last_mode_led;
    logic [2:0]   seen_modes [$];
    logic [2:0]   expected_modes [$];
    mode_t        model_mode;
    disp_fields_t watch_model;
    disp_fields_t cook_model;

    multifunction_watch_top #(
        .DEBOUNCE_CLKS(DEBOUNCE_CLKS),
        .CLKS_PER_CSEC(CLKS_PER_CSEC),
        .SCAN_CLKS(SCAN_CLKS)
    ) UUT (
        .clk(clk), .reset_p(reset_p), .button(button), .slide(slide),
        .seg(seg), .com(com), .led(led), .buz(buz));

    always #2 clk = ~clk;

    //----------------------------------------------------------------------
    // Reference model of the display
    //----------------------------------------------------------------------
    // Active low with segment a on bit 0 and the decimal point off
    function automatic logic [7:0] digit_pattern(input int digit);
        case (digit)
            0:       return 8'hC0;
            1:       return 8'hF9;
            2:       return 8'hA4;
            3:       return 8'hB0;
            4:       return 8'h99;
            5:       return 8'h92;
            6:       return 8'h82;
            7:       return 8'hF8;
            8:       return 8'h80;
            9:       return 8'h90;
            default: return 8'hFF;
        endcase
    endfunction

    function automatic int decode_digit(input logic [7:0] pattern);
        for (int d = 0; d < 10; d++) begin
            if (digit_pattern(d) == pattern) return d;
        end
        return -1;
    endfunction

    // Digit 3 on the left and digit 0 on the right
    function automatic logic [31:0] expected_display(input disp_fields_t fields);
        int lo;
        int hi;
        lo = int'(fields.low);
        hi = int'(fields.high);
        return {digit_pattern(hi / 10), digit_pattern(hi % 10),
                digit_pattern(lo / 10), digit_pattern(lo % 10)};
    endfunction

    function automatic disp_fields_t decode_display(input logic [31:0] segs);
        disp_fields_t fields;
        fields.high = field_t'(10 * decode_digit(segs[31:24]) + decode_digit(segs[23:16]));
        fields.low  = field_t'(10 * decode_digit(segs[15:8]) + decode_digit(segs[7:0]));
        return fields;
    endfunction

    function automatic field_t add_wrap(input field_t value, input int steps);
        return field_t'((int'(value) + steps) % 60);
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] actual,
                                   input logic [31:0] expected);
        errors++;
        $display("Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, actual, expected);
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("Error at %0t ns: %s", $time, what);
    endtask

    //----------------------------------------------------------------------
    // Stimulus and reading helpers
    //----------------------------------------------------------------------
    task automatic press_button(input int idx);
        @(posedge clk);
        #1 button[idx] = 1'b1;
        repeat (3 * DEBOUNCE_CLKS) @(posedge clk);
        #1 button[idx] = 1'b0;
        repeat (3 * DEBOUNCE_CLKS) @(posedge clk);
    endtask

    task automatic change_mode();
        press_button(3);
        case (model_mode)
            WATCH:      model_mode = COOK_TIMER;
            COOK_TIMER: model_mode = STOPWATCH;
            default:    model_mode = WATCH;
        endcase
        expected_modes.push_back(model_mode);
        @(negedge clk);
        checks++;
        if (led[7:5] !== model_mode) report_mismatch("led[7:5]", 32'(led[7:5]), 32'(model_mode));
    endtask

    // One full scan so that every digit is seen at least once
    task automatic read_display(output logic [31:0] segs);
        segs = '1;
        repeat (4 * SCAN_CLKS) begin
            @(negedge clk);
            for (int k = 0; k < 4; k++) begin
                if (com[k] == 1'b0) segs[8*k +: 8] = seg;
            end
        end
    endtask

    task automatic check_display(input disp_fields_t expected);
        logic [31:0] segs;
        read_display(segs);
        checks++;
        if (segs !== expected_display(expected)) begin
            report_mismatch("seg digits", segs, expected_display(expected));
        end
    endtask

    task automatic check_leds(input logic [2:0] mode_led, input logic alarm_on,
                              input logic lap_on, input logic run_on);
        logic [15:0] expected;
        expected      = '0;                 // Unused LEDs stay dark
        expected[15]  = alarm_on;
        expected[7:5] = mode_led;
        expected[1]   = lap_on;
        expected[0]   = run_on;
        @(negedge clk);
        checks += 2;
        if (led !== expected) report_mismatch("led", 32'(led), 32'(expected));
        if (buz !== alarm_on) report_mismatch("buz", 32'(buz), 32'(alarm_on));
    endtask

    // Scan legality, mode LED history and alarm edges
    always @(negedge clk) begin
        if (!reset_p) begin
            if ($countones(~com) != 1) begin
                scan_errors++;
                $display("Error at %0t ns: com = %b has not exactly one low bit", $time, com);
            end
            if (decode_digit(seg) < 0) begin
                scan_errors++;
                $display("Error at %0t ns: seg = 0x%h is no digit with dp off", $time, seg);
            end
            if (led[7:5] !== last_mode_led) seen_modes.push_back(led[7:5]);
            if (led[15] && !last_alarm) alarm_rises++;
            last_mode_led = led[7:5];
            last_alarm    = led[15];
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("Error: run stopped after %0d cycles, a wait never ended", cycle_count);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial begin
        logic [31:0] segs_a;
        logic [31:0] segs_b;
        int          waited;
        int          rises_before;
        clk = 1'b0;
        reset_p = 1'b1;
        button = '0;
        slide = '0;
        errors = 0;
        scan_errors = 0;
        checks = 0;
        cycle_count = 0;
        alarm_rises = 0;
        last_alarm = 1'b0;
        last_mode_led = 3'b000;
        model_mode = WATCH;
        expected_modes.push_back(WATCH);
        cook_model = '0;
        repeat (2) @(posedge clk);
        #1 reset_p = 1'b0;

        check_leds(WATCH, 1'b0, 1'b0, 1'b0);
        check_display('0);

        //------------------------------------------------------------------
        // Watch set mode
        //------------------------------------------------------------------
        press_button(0);
        read_display(segs_a);
        watch_model = decode_display(segs_a);
        repeat (3) press_button(1);
        repeat (2) press_button(2);
        watch_model.low  = add_wrap(watch_model.low, 3);
        watch_model.high = add_wrap(watch_model.high, 2);
        check_display(watch_model);
        repeat (300 * CLKS_PER_CSEC) @(posedge clk);
        check_display(watch_model);                  // Still held

        //------------------------------------------------------------------
        // Cook timer from 00:03 down to the alarm
        //------------------------------------------------------------------
        change_mode();
        repeat (3) press_button(1);
        cook_model.low = 7'd3;
        check_display(cook_model);
        press_button(0);
        waited = 0;
        while (led[15] !== 1'b1 && waited < 4 * SEC_CLKS) begin
            @(negedge clk);
            waited++;
        end
        checks++;
        if (led[15] !== 1'b1) report_failure("cook timer alarm did not rise within 4 seconds");
        cook_model = '0;
        check_leds(COOK_TIMER, 1'b1, 1'b0, 1'b0);
        check_display(cook_model);
        @(posedge clk);
        #1 slide[0] = 1'b1;
        waited = 0;
        while (led[15] !== 1'b0 && waited < 10) begin
            @(negedge clk);
            waited++;
        end
        @(posedge clk);
        #1 slide[0] = 1'b0;
        check_leds(COOK_TIMER, 1'b0, 1'b0, 1'b0);

        //------------------------------------------------------------------
        // Stopwatch stop, lap and clear
        //------------------------------------------------------------------
        change_mode();
        press_button(0);
        check_leds(STOPWATCH, 1'b0, 1'b0, 1'b1);
        repeat (200) @(posedge clk);
        press_button(0);
        check_leds(STOPWATCH, 1'b0, 1'b0, 1'b0);
        read_display(segs_a);
        repeat (SEC_CLKS) @(posedge clk);
        read_display(segs_b);
        checks += 2;
        if (segs_a == expected_display('0)) report_failure("stopwatch did not count");
        if (segs_b !== segs_a) report_mismatch("stopped seg digits", segs_b, segs_a);
        press_button(0);
        press_button(1);
        check_leds(STOPWATCH, 1'b0, 1'b1, 1'b1);
        read_display(segs_a);
        repeat (SEC_CLKS) @(posedge clk);
        read_display(segs_b);
        checks++;
        if (segs_b !== segs_a) report_mismatch("lap seg digits", segs_b, segs_a);
        press_button(1);
        check_leds(STOPWATCH, 1'b0, 1'b0, 1'b1);
        read_display(segs_b);
        checks++;
        if (segs_b == segs_a) report_failure("stopwatch did not count under the lap view");
        press_button(0);
        press_button(2);
        check_display('0);
        check_leds(STOPWATCH, 1'b0, 1'b0, 1'b0);

        //------------------------------------------------------------------
        // Buttons reach the active function only
        //------------------------------------------------------------------
        rises_before = alarm_rises;
        change_mode();
        change_mode();
        repeat (2) press_button(1);
        press_button(2);
        cook_model.low  = 7'd2;
        cook_model.high = 7'd1;
        check_display(cook_model);
        change_mode();
        press_button(0);                             // Start and lap on while clear is ignored
        press_button(1);
        press_button(2);
        repeat (SEC_CLKS + 100) @(posedge clk);
        change_mode();
        change_mode();
        check_display(cook_model);
        check_leds(COOK_TIMER, 1'b0, 1'b1, 1'b1);
        checks += 2;
        if (alarm_rises != rises_before) report_failure("alarm rose during mode routing");
        if (seen_modes.size() != expected_modes.size()) begin
            report_mismatch("mode LED changes", seen_modes.size(), expected_modes.size());
        end else begin
            for (int k = 0; k < seen_modes.size(); k++) begin
                if (seen_modes[k] !== expected_modes[k]) begin
                    report_mismatch("led[7:5] history", 32'(seen_modes[k]),
                                    32'(expected_modes[k]));
                end
            end
        end

        $display("Checks: %0d, errors: %0d, scan errors: %0d", checks, errors, scan_errors);
        if (errors == 0 && scan_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- compile.f
design/watch_pkg.sv
design/button_cntr.sv
design/time_base.sv
design/clock_watch.sv
design/cook_timer.sv
design/stop_watch.sv
design/mode_select.sv
design/fnd_cntr.sv
design/multifunction_watch_top.sv
testbench/tb_multifunction_watch.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_multifunction_watch -f compile.f -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Result: PASSED" sim.log; then
    echo "Simulation run is clean"
    exit 0
fi
echo "Simulation run reported errors"
exit 1
